/* list.f */
source/tetris_pkg.sv
source/input_sync.sv
source/piece_unit.sv
source/board_store.sv
source/game_ctrl.sv
source/display_out.sv
source/tetris_top.sv
tests/tetris_props.sv
tests/tetris_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tetris_tb -Mdir build -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./build/Vtetris_tb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -F -q "*** FAILED ***" sim.log; then
    exit 1
fi
exit 0

/* source/board_store.sv */
`default_nettype none
`timescale 1ns/10ps

module board_store (
    input  logic                           clk,
    input  logic                           reset,
    input  tetris_pkg::board_cmd_t         cmd_i,
    input  tetris_pkg::board_t             mask_i,
    output tetris_pkg::board_t             board_o,
    output logic [tetris_pkg::SCORE_W-1:0] score_o,
    output logic                           clear_done_o,
    output logic                           top_occupied_o
);

    import tetris_pkg::*;

    board_t             board_q;
    row_t               scan_q;
    logic               busy_q;
    logic [SCORE_W-1:0] score_q;
    logic               row_full;

    assign row_full       = &board_q[scan_q];
    assign board_o        = board_q;
    assign score_o        = score_q;
    assign top_occupied_o = |board_q[0];

    // ==============================
    // Merge, line clear and score
    // ==============================

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            board_q      <= '0;
            scan_q       <= '0;
            busy_q       <= 1'b0;
            score_q      <= '0;
            clear_done_o <= 1'b0;
        end else begin
            clear_done_o <= 1'b0;
            if (cmd_i.wipe) begin
                board_q <= '0;
                busy_q  <= 1'b0;
                score_q <= '0;
            end else if (cmd_i.merge) begin
                board_q <= board_q | mask_i;
            end else if (cmd_i.clear_start) begin
                // Scan starts at the bottom row
                busy_q <= 1'b1;
                scan_q <= row_t'(ROWS - 1);
            end else if (busy_q) begin
                if (row_full) begin
                    // Drop everything above the full row by one
                    for (int r = 1; r < ROWS; r++) begin
                        if (r <= int'(scan_q)) begin
                            board_q[r] <= board_q[r-1];
                        end
                    end
                    board_q[0] <= '0;
                    score_q    <= score_q + 1'b1;
                    // Same row index is checked again next cycle
                end else if (scan_q == '0) begin
                    busy_q       <= 1'b0;
                    clear_done_o <= 1'b1;
                end else begin
                    scan_q <= scan_q - row_t'(1);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/display_out.sv */
`default_nettype none
`timescale 1ns/10ps

module display_out (
    input  logic                    clk,
    input  logic                    reset,
    input  tetris_pkg::game_state_t state_i,
    input  tetris_pkg::board_t      board_i,
    input  tetris_pkg::board_t      mask_i,
    output tetris_pkg::board_t      display_o,
    output logic                    gameover_o
);

    import tetris_pkg::*;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            display_o  <= '0;
            gameover_o <= 1'b0;
        end else begin
            case (state_i)
                INIT, RESTART: display_o <= '0;
                // No live piece in these states
                LANDED, EVAL, GAMEOVER: display_o <= board_i;
                default: display_o <= board_i | mask_i;
            endcase
            gameover_o <= (state_i == GAMEOVER);
        end
    end

endmodule

`default_nettype wire

/* source/game_ctrl.sv */
`default_nettype none
`timescale 1ns/10ps

module game_ctrl (
    input  logic                     clk,
    input  logic                     reset,
    input  tetris_pkg::key_strobes_t strobes_i,
    input  logic                     bottom_hit_i,
    input  logic                     clear_done_i,
    input  logic                     top_occupied_i,
    output tetris_pkg::piece_cmd_t   piece_cmd_o,
    output tetris_pkg::board_cmd_t   board_cmd_o,
    output tetris_pkg::piece_t       next_piece_o,
    output tetris_pkg::game_state_t  state_o
);

    import tetris_pkg::*;

    game_state_t state_q;
    game_state_t state_d;
    logic        grace_q;
    logic [7:0]  lfsr_q;
    logic        stick;

    assign state_o = state_q;

    // Second drop tick while resting on something
    assign stick = strobes_i.drop_tick & bottom_hit_i & grace_q;

    // Unused code 7 falls back to the I piece
    assign next_piece_o.shape = (lfsr_q[2:0] < 3'(NUM_SHAPES)) ? lfsr_q[2:0] : SHAPE_I;
    assign next_piece_o.rot   = 2'd0;

    // ==============================
    // FSM
    // ==============================

    always_comb begin
        state_d     = state_q;
        piece_cmd_o = '0;
        board_cmd_o = '0;
        case (state_q)
            INIT: if (strobes_i.start) state_d = SPAWN;
            SPAWN: begin
                piece_cmd_o.spawn = 1'b1;
                state_d           = FALLING;
            end
            FALLING: begin
                piece_cmd_o.fall = strobes_i.drop_tick;
                if (stick) begin
                    state_d = STUCK;
                end else begin
                    piece_cmd_o.shift_left  = strobes_i.left;
                    piece_cmd_o.shift_right = strobes_i.right;
                    if (strobes_i.rotate) state_d = ROTATE;
                end
            end
            ROTATE: begin
                piece_cmd_o.rotate = 1'b1;
                state_d            = FALLING;
            end
            STUCK: begin
                board_cmd_o.merge = 1'b1;
                state_d           = top_occupied_i ? GAMEOVER : LANDED;
            end
            LANDED: begin
                board_cmd_o.clear_start = 1'b1;
                state_d                 = EVAL;
            end
            EVAL: if (clear_done_i) state_d = SPAWN;
            GAMEOVER: if (strobes_i.right) state_d = RESTART;
            RESTART: begin
                board_cmd_o.wipe = 1'b1;
                if (strobes_i.start) state_d = SPAWN;
            end
            default: state_d = INIT;
        endcase
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state_q <= INIT;
            grace_q <= 1'b0;
            lfsr_q  <= 8'hA5;
        end else begin
            state_q <= state_d;
            // Taps 8, 6, 5, 4
            lfsr_q  <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
            // Grace survives a rotation, clears once the piece is free again
            if (state_q == FALLING) begin
                grace_q <= bottom_hit_i;
            end else if (state_q != ROTATE) begin
                grace_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* source/input_sync.sv */
`default_nettype none
`timescale 1ns/10ps

module input_sync (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     left_i,
    input  logic                     right_i,
    input  logic                     rotate_i,
    input  logic                     start_i,
    input  logic                     gravity_i,
    output tetris_pkg::key_strobes_t strobes_o
);

    import tetris_pkg::*;

    // Bit order: left, right, rotate, start, gravity
    logic [4:0] raw;
    logic [4:0] sync0_q;
    logic [4:0] sync1_q;
    logic [4:0] prev_q;
    logic [4:0] rise;
    logic [4:0] fall;

    assign raw  = {left_i, right_i, rotate_i, start_i, gravity_i};
    assign rise = sync1_q & ~prev_q;
    assign fall = ~sync1_q & prev_q;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            sync0_q   <= '0;
            sync1_q   <= '0;
            prev_q    <= '0;
            strobes_o <= '0;
        end else begin
            sync0_q <= raw;
            sync1_q <= sync0_q;
            prev_q  <= sync1_q;
            // Keys fire on press, gravity on its falling edge
            strobes_o.left      <= rise[4];
            strobes_o.right     <= rise[3];
            strobes_o.rotate    <= rise[2];
            strobes_o.start     <= rise[1];
            strobes_o.drop_tick <= fall[0];
        end
    end

endmodule

`default_nettype wire

/* source/piece_unit.sv */
`default_nettype none
`timescale 1ns/10ps

module piece_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  tetris_pkg::piece_cmd_t cmd_i,
    input  tetris_pkg::piece_t     spawn_piece_i,
    input  tetris_pkg::board_t     board_i,
    output tetris_pkg::board_t     mask_o,
    output logic                   bottom_hit_o
);

    import tetris_pkg::*;

    piece_t     piece_q;
    piece_t     rot_piece;
    piece_pos_t pos_q;
    logic [15:0] cur_pat;
    logic [15:0] rot_pat;
    row_t       row_after;
    logic       can_fall;
    logic       can_left;
    logic       can_right;
    logic       can_rot;

    // ==============================
    // Shape table
    // ==============================

    // Row 0 first, column 0 leftmost; patterns sit in the top-left corner
    function automatic logic [15:0] shape_pattern(input piece_t p);
        logic [15:0] pat;
        pat = '0;
        case (p.shape)
            SHAPE_I: pat = p.rot[0] ? 16'b1000_1000_1000_1000 : 16'b1111_0000_0000_0000;
            SHAPE_O: pat = 16'b1100_1100_0000_0000;
            SHAPE_S: pat = p.rot[0] ? 16'b1000_1100_0100_0000 : 16'b0110_1100_0000_0000;
            SHAPE_Z: pat = p.rot[0] ? 16'b0100_1100_1000_0000 : 16'b1100_0110_0000_0000;
            SHAPE_J: begin
                case (p.rot)
                    2'd0: pat = 16'b1000_1110_0000_0000;
                    2'd1: pat = 16'b1100_1000_1000_0000;
                    2'd2: pat = 16'b1110_0010_0000_0000;
                    default: pat = 16'b0100_0100_1100_0000;
                endcase
            end
            SHAPE_L: begin
                case (p.rot)
                    2'd0: pat = 16'b0010_1110_0000_0000;
                    2'd1: pat = 16'b1000_1000_1100_0000;
                    2'd2: pat = 16'b1110_1000_0000_0000;
                    default: pat = 16'b1100_0100_0100_0000;
                endcase
            end
            default: begin
                case (p.rot)
                    2'd0: pat = 16'b0100_1110_0000_0000;
                    2'd1: pat = 16'b1000_1100_1000_0000;
                    2'd2: pat = 16'b1110_0100_0000_0000;
                    default: pat = 16'b0100_1100_0100_0000;
                endcase
            end
        endcase
        return pat;
    endfunction

    // Clockwise step, modulo the orientations of the shape
    function automatic logic [1:0] next_rot(input piece_t p);
        case (p.shape)
            SHAPE_O: return 2'd0;
            SHAPE_I, SHAPE_S, SHAPE_Z: return {1'b0, ~p.rot[0]};
            default: return p.rot + 2'd1;
        endcase
    endfunction

    // Pattern inside the board and clear of settled cells
    function automatic logic fits(input logic [15:0] pat, input int row, input int col,
                                  input board_t brd);
        int   rr;
        int   cc;
        logic ok;
        ok = 1'b1;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                rr = row + r;
                cc = col + c;
                if (pat[15 - 4*r - c]) begin
                    if (rr < 0 || rr >= ROWS || cc < 0 || cc >= COLS) begin
                        ok = 1'b0;
                    end else if (brd[rr][cc]) begin
                        ok = 1'b0;
                    end
                end
            end
        end
        return ok;
    endfunction

    function automatic board_t to_mask(input logic [15:0] pat, input piece_pos_t pos);
        board_t m;
        int     rr;
        int     cc;
        m = '0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                rr = int'(pos.row) + r;
                cc = int'(pos.col) + c;
                if (pat[15 - 4*r - c] && rr < ROWS && cc < COLS) begin
                    m[rr][cc] = 1'b1;
                end
            end
        end
        return m;
    endfunction

    // ==============================
    // Collision checks
    // ==============================

    assign cur_pat   = shape_pattern(piece_q);
    assign rot_piece = '{shape: piece_q.shape, rot: next_rot(piece_q)};
    assign rot_pat   = shape_pattern(rot_piece);

    always_comb begin
        can_fall  = fits(cur_pat, int'(pos_q.row) + 1, int'(pos_q.col), board_i);
        row_after = (cmd_i.fall && can_fall) ? pos_q.row + row_t'(1) : pos_q.row;
        // Sideways moves are checked at the row after any fall
        can_left  = fits(cur_pat, int'(row_after), int'(pos_q.col) - 1, board_i);
        can_right = fits(cur_pat, int'(row_after), int'(pos_q.col) + 1, board_i);
        can_rot   = fits(rot_pat, int'(pos_q.row), int'(pos_q.col), board_i);
    end

    assign bottom_hit_o = ~can_fall;
    assign mask_o       = to_mask(cur_pat, pos_q);

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            piece_q   <= '0;
            pos_q.row <= '0;
            pos_q.col <= col_t'(SPAWN_COL);
        end else if (cmd_i.spawn) begin
            piece_q   <= spawn_piece_i;
            pos_q.row <= '0;
            pos_q.col <= col_t'(SPAWN_COL);
        end else begin
            pos_q.row <= row_after;
            if (cmd_i.shift_left && can_left) begin
                pos_q.col <= pos_q.col - col_t'(1);
            end else if (cmd_i.shift_right && can_right) begin
                pos_q.col <= pos_q.col + col_t'(1);
            end
            if (cmd_i.rotate && can_rot) begin
                piece_q.rot <= rot_piece.rot;
            end
        end
    end

endmodule

`default_nettype wire

/* source/tetris_pkg.sv */
`default_nettype none

package tetris_pkg;

    // Board geometry
    localparam int ROWS       = 20;
    localparam int COLS       = 10;
    localparam int SPAWN_COL  = 3;
    localparam int NUM_SHAPES = 7;
    localparam int SCORE_W    = 10;

    // Shape codes
    localparam logic [2:0] SHAPE_I = 3'd0;
    localparam logic [2:0] SHAPE_O = 3'd1;
    localparam logic [2:0] SHAPE_S = 3'd2;
    localparam logic [2:0] SHAPE_Z = 3'd3;
    localparam logic [2:0] SHAPE_J = 3'd4;
    localparam logic [2:0] SHAPE_L = 3'd5;
    localparam logic [2:0] SHAPE_T = 3'd6;

    typedef logic [ROWS-1:0][COLS-1:0] board_t;
    typedef logic [4:0] row_t;
    typedef logic [3:0] col_t;

    typedef struct packed {
        logic [2:0] shape;
        logic [1:0] rot;
    } piece_t;

    // Top-left corner of the 4x4 window
    typedef struct packed {
        row_t row;
        col_t col;
    } piece_pos_t;

    typedef struct packed {
        logic left;
        logic right;
        logic rotate;
        logic start;
        logic drop_tick;
    } key_strobes_t;

    typedef struct packed {
        logic spawn;
        logic fall;
        logic shift_left;
        logic shift_right;
        logic rotate;
    } piece_cmd_t;

    typedef struct packed {
        logic merge;
        logic clear_start;
        logic wipe;
    } board_cmd_t;

    typedef enum logic [3:0] {
        INIT, SPAWN, FALLING, ROTATE, STUCK, LANDED, EVAL, GAMEOVER, RESTART
    } game_state_t;

endpackage

`default_nettype wire

/* source/tetris_top.sv */
`default_nettype none
`timescale 1ns/10ps

module tetris_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           left_i,
    input  logic                           right_i,
    input  logic                           rotate_i,
    input  logic                           start_i,
    input  logic                           gravity_i,
    output tetris_pkg::board_t             display_o,
    output logic [tetris_pkg::SCORE_W-1:0] score_o,
    output logic                           gameover_o,
    output tetris_pkg::game_state_t        state_o
);

    import tetris_pkg::*;

    key_strobes_t strobes;
    piece_cmd_t   piece_cmd;
    board_cmd_t   board_cmd;
    piece_t       next_piece;
    board_t       board;
    board_t       mask;
    logic         bottom_hit;
    logic         clear_done;
    logic         top_occupied;

    // ==============================
    // Input side
    // ==============================

    input_sync input_sync_i (
        .clk(clk),
        .reset(reset),
        .left_i(left_i),
        .right_i(right_i),
        .rotate_i(rotate_i),
        .start_i(start_i),
        .gravity_i(gravity_i),
        .strobes_o(strobes)
    );

    // ==============================
    // Game core
    // ==============================

    game_ctrl game_ctrl_i (
        .clk(clk),
        .reset(reset),
        .strobes_i(strobes),
        .bottom_hit_i(bottom_hit),
        .clear_done_i(clear_done),
        .top_occupied_i(top_occupied),
        .piece_cmd_o(piece_cmd),
        .board_cmd_o(board_cmd),
        .next_piece_o(next_piece),
        .state_o(state_o)
    );

    piece_unit piece_unit_i (
        .clk(clk),
        .reset(reset),
        .cmd_i(piece_cmd),
        .spawn_piece_i(next_piece),
        .board_i(board),
        .mask_o(mask),
        .bottom_hit_o(bottom_hit)
    );

    board_store board_store_i (
        .clk(clk),
        .reset(reset),
        .cmd_i(board_cmd),
        .mask_i(mask),
        .board_o(board),
        .score_o(score_o),
        .clear_done_o(clear_done),
        .top_occupied_o(top_occupied)
    );

    // Output side
    display_out display_out_i (
        .clk(clk),
        .reset(reset),
        .state_i(state_o),
        .board_i(board),
        .mask_i(mask),
        .display_o(display_o),
        .gameover_o(gameover_o)
    );

endmodule

`default_nettype wire

/* tests/tetris_props.sv */
`default_nettype none
`timescale 1ns/10ps

module tetris_props (
    input  logic                           clk,
    input  logic                           reset,
    input  tetris_pkg::game_state_t        state_i,
    input  tetris_pkg::board_t             display_i,
    input  logic [tetris_pkg::SCORE_W-1:0] score_i,
    input  logic                           gameover_i,
    input  tetris_pkg::board_t             board_i,
    input  tetris_pkg::board_t             mask_i,
    input  tetris_pkg::piece_cmd_t         piece_cmd_i,
    input  tetris_pkg::key_strobes_t       strobes_i
);

    import tetris_pkg::*;

    int                 fail_count = 0;
    // State whose view the display register holds this cycle
    game_state_t        shown_state_q;
    logic               clean_q;
    logic [SCORE_W-1:0] shown_score_q;
    int                 base_q;
    int                 landed_cnt_q;
    logic [SCORE_W-1:0] landed_score_q;
    logic               left_moved_q;
    int                 cells;
    logic               left_cols;

    function automatic int count_cells(input board_t b);
        int n;
        n = 0;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                n = n + int'(b[r][c]);
            end
        end
        return n;
    endfunction

    assign cells = count_cells(display_i);

    always_comb begin
        left_cols = 1'b0;
        for (int r = 0; r < ROWS; r++) begin
            left_cols = left_cols | (|mask_i[r][2:0]);
        end
    end

    // ==============================
    // Reference history
    // ==============================

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            shown_state_q  <= INIT;
            clean_q        <= 1'b1;
            shown_score_q  <= '0;
            base_q         <= 0;
            landed_cnt_q   <= 0;
            landed_score_q <= '0;
            left_moved_q   <= 1'b0;
        end else begin
            shown_state_q <= state_i;
            // A piece spawned onto settled cells does not add four cells
            clean_q       <= ~|(board_i & mask_i);
            shown_score_q <= score_i;
            if (shown_state_q == LANDED || shown_state_q == EVAL || shown_state_q == RESTART) begin
                base_q <= cells;
            end
            if (shown_state_q == LANDED) begin
                landed_cnt_q   <= cells;
                landed_score_q <= shown_score_q;
            end
            if (piece_cmd_i.spawn) begin
                left_moved_q <= 1'b0;
            end else if (piece_cmd_i.shift_left) begin
                left_moved_q <= 1'b1;
            end
        end
    end

    // ==============================
    // Game rules
    // ==============================

    init_idle: assert property (@(posedge clk) disable iff (reset)
        state_i == INIT |-> display_i == '0 && score_i == '0 && !gameover_i)
        else begin
            fail_count++;
            $error({"error at %0t: display_o cells %0d score_o %0d gameover_o %0b in INIT,",
                    " expected 0, 0 and 0"},
                   $time, cells, score_i, gameover_i);
        end

    piece_cells: assert property (@(posedge clk) disable iff (reset)
        (shown_state_q == FALLING || shown_state_q == ROTATE) && clean_q
        |-> cells == base_q + 4)
        else begin
            fail_count++;
            $error("error at %0t: display_o cells %0d, expected %0d", $time, cells, base_q + 4);
        end

    clear_count: assert property (@(posedge clk) disable iff (reset)
        shown_state_q == EVAL
        |-> cells + 10 * int'(shown_score_q - landed_score_q) == landed_cnt_q)
        else begin
            fail_count++;
            $error("error at %0t: display_o cells %0d, expected %0d", $time, cells,
                   landed_cnt_q - 10 * int'(shown_score_q - landed_score_q));
        end

    score_hold: assert property (@(posedge clk) disable iff (reset)
        score_i != shown_score_q
        |-> shown_state_q == EVAL || (shown_state_q == RESTART && score_i == '0))
        else begin
            fail_count++;
            $error("error at %0t: score_o %0d, expected %0d", $time, score_i, shown_score_q);
        end

    no_left_drift: assert property (@(posedge clk) disable iff (reset)
        state_i == FALLING && !left_moved_q |-> !left_cols)
        else begin
            fail_count++;
            $error("Piece entered columns 0 to 2 without a left shift");
        end

    gameover_flag: assert property (@(posedge clk) disable iff (reset)
        gameover_i == (shown_state_q == GAMEOVER))
        else begin
            fail_count++;
            $error("error at %0t: gameover_o %0b, expected %0b", $time, gameover_i,
                   shown_state_q == GAMEOVER);
        end

    restart_entry: assert property (@(posedge clk) disable iff (reset)
        state_i == GAMEOVER && strobes_i.right |=> state_i == RESTART)
        else begin
            fail_count++;
            $error("Right key in GAMEOVER did not lead to RESTART");
        end

    restart_clean: assert property (@(posedge clk) disable iff (reset)
        shown_state_q == RESTART |-> display_i == '0 && score_i == '0)
        else begin
            fail_count++;
            $error("error at %0t: display_o cells %0d score_o %0d in RESTART, expected 0 and 0",
                   $time, cells, score_i);
        end

endmodule

bind tetris_top tetris_props tetris_props_i (
    .clk(clk),
    .reset(reset),
    .state_i(state_o),
    .display_i(display_o),
    .score_i(score_o),
    .gameover_i(gameover_o),
    .board_i(board),
    .mask_i(mask),
    .piece_cmd_i(piece_cmd),
    .strobes_i(strobes)
);

`default_nettype wire

/* tests/tetris_tb.sv */
`default_nettype none
`timescale 1ns/10ps

module tetris_tb;

    import tetris_pkg::*;

    localparam int GAMES        = 3;
    localparam int MAX_PIECES   = 200;
    // 20 rows at one drop per 32 cycles, plus grace tick and line clear
    localparam int PIECE_CYCLES = 800;
    localparam int WATCHDOG_NS  = GAMES * MAX_PIECES * PIECE_CYCLES * 10;
    localparam int STEER_PIECES = 40;
    localparam int KEY_LEFT     = 0;
    localparam int KEY_RIGHT    = 1;
    localparam int KEY_ROTATE   = 2;
    localparam int KEY_START    = 3;

    logic               clk;
    logic               reset;
    logic               left_i;
    logic               right_i;
    logic               rotate_i;
    logic               start_i;
    logic               gravity_i;
    board_t             display_o;
    logic [SCORE_W-1:0] score_o;
    logic               gameover_o;
    game_state_t        state_o;

    logic [31:0]        rand_q;
    logic [SCORE_W-1:0] last_score;
    board_t             settled;
    int                 score_rises;
    int                 edge_hits;
    int                 other_errors;
    int                 fails;

    tetris_top tetris_top_i (
        .clk(clk),
        .reset(reset),
        .left_i(left_i),
        .right_i(right_i),
        .rotate_i(rotate_i),
        .start_i(start_i),
        .gravity_i(gravity_i),
        .display_o(display_o),
        .score_o(score_o),
        .gameover_o(gameover_o),
        .state_o(state_o)
    );

    always #5 clk = ~clk;

    // Slow gravity square wave
    always begin
        repeat (16) @(posedge clk);
        #1;
        gravity_i = ~gravity_i;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Leftmost column with the lowest stack
    function automatic int lowest_column(input board_t b);
        int best;
        int best_h;
        int h;
        best   = 0;
        best_h = ROWS + 1;
        for (int c = 0; c < COLS; c++) begin
            h = 0;
            for (int r = 0; r < ROWS; r++) begin
                if (b[r][c] && h == 0) begin
                    h = ROWS - r;
                end
            end
            if (h < best_h) begin
                best   = c;
                best_h = h;
            end
        end
        return best;
    endfunction

    function automatic logic column0_used(input board_t b);
        logic used;
        used = 1'b0;
        for (int r = 0; r < ROWS; r++) begin
            used = used | b[r][0];
        end
        return used;
    endfunction

    // ==============================
    // Stimulus
    // ==============================

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic press_key(input int key);
        case (key)
            KEY_LEFT:   left_i = 1'b1;
            KEY_RIGHT:  right_i = 1'b1;
            KEY_ROTATE: rotate_i = 1'b1;
            default:    start_i = 1'b1;
        endcase
        wait_cycles(4);
        left_i   = 1'b0;
        right_i  = 1'b0;
        rotate_i = 1'b0;
        start_i  = 1'b0;
        wait_cycles(4);
    endtask

    // Rotate a few times, then push the piece towards a target column
    task automatic steer_piece(input board_t brd);
        int target;
        int turns;
        rand_q = xorshift(rand_q);
        turns  = int'(rand_q[1:0]) % 3;
        if (rand_q[4:2] == 3'd0) begin
            target = int'(rand_q[11:8]) % COLS;
        end else begin
            target = lowest_column(brd);
        end
        repeat (turns) press_key(KEY_ROTATE);
        if (target < SPAWN_COL) begin
            repeat (SPAWN_COL - target) press_key(KEY_LEFT);
        end else begin
            repeat (target - SPAWN_COL) press_key(KEY_RIGHT);
        end
    endtask

    // Late pieces are left alone so the center stack ends the game
    task automatic play_game();
        int   pieces;
        logic over;
        pieces = 0;
        over   = 1'b0;
        press_key(KEY_START);
        while (!over) begin
            while (state_o != SPAWN && state_o != GAMEOVER && state_o != RESTART) begin
                next_cycle();
            end
            if (state_o == SPAWN) begin
                settled = display_o;
                next_cycle();
                if (pieces < STEER_PIECES) begin
                    steer_piece(settled);
                end
                pieces++;
            end else begin
                over = 1'b1;
            end
        end
        press_key(KEY_RIGHT);
        while (state_o != RESTART) begin
            next_cycle();
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            if (score_o > last_score) begin
                score_rises++;
            end
            last_score = score_o;
            if (state_o == FALLING && column0_used(display_o)) begin
                edge_hits++;
            end
        end
    end

    // ==============================
    // Main sequence and report
    // ==============================

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        left_i       = 1'b0;
        right_i      = 1'b0;
        rotate_i     = 1'b0;
        start_i      = 1'b0;
        gravity_i    = 1'b0;
        rand_q       = 32'h74b4ec74;
        last_score   = '0;
        settled      = '0;
        score_rises  = 0;
        edge_hits    = 0;
        other_errors = 0;
        fails        = 0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        // Idle in INIT for a while before the first start
        wait_cycles(20);
        for (int g = 0; g < GAMES; g++) begin
            play_game();
        end
        wait_cycles(10);
        if (score_rises == 0) begin
            $display("No line was cleared in any of the games");
            other_errors++;
        end
        if (edge_hits == 0) begin
            $display("No falling piece ever reached column 0");
            other_errors++;
        end
        fails = tetris_top_i.tetris_props_i.fail_count;
        $display("Summary: %0d assertion failures, %0d other errors, %0d score increases",
                 fails, other_errors, score_rises);
        if (fails == 0 && other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the games did not finish", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
